//--- fp_alu_consts.svh
`ifndef FP_ALU_CONSTS_SVH
`define FP_ALU_CONSTS_SVH

// word layout of a single-precision float.
`define FP_WIDTH      32
`define FP_EXP_WIDTH  8
`define FP_FRAC_WIDTH 23
`define FP_SIG_WIDTH  24
`define FP_SIGN_BIT   31
`define FP_EXP_LSB    23

// exponent offset removed after a multiply.
// the arithmetic stage takes one more off when the product is below two.
`define FP_BIAS_MUL 8'd126

// opcodes of the supported operations.
`define FP_OP_WIDTH 5
`define FP_OP_ADD   5'd16
`define FP_OP_SUB   5'd17
`define FP_OP_MUL   5'd18
`define FP_OP_NOP   5'd22
`define FP_OP_SLT   5'd23

// cycles from an accepted input to its result.
`define FP_LATENCY 3

`endif

//--- fp_alu_pkg.sv
`default_nettype none

`include "fp_alu_consts.svh"

package fp_alu_pkg;

    typedef logic [`FP_WIDTH-1:0]           fp_word_t;
    typedef logic [`FP_EXP_WIDTH-1:0]       fp_exp_t;
    typedef logic [`FP_SIG_WIDTH-1:0]       fp_sig_t;
    typedef logic [`FP_SIG_WIDTH:0]         fp_mag_t;
    typedef logic [2*`FP_SIG_WIDTH-1:0]     fp_prod_t;

    typedef enum logic [`FP_OP_WIDTH-1:0] {
        op_add = `FP_OP_ADD,
        op_sub = `FP_OP_SUB,
        op_mul = `FP_OP_MUL,
        op_nop = `FP_OP_NOP,
        op_slt = `FP_OP_SLT
    } fp_op_e;

    // operands after unpacking and alignment.
    // sign_b is already inverted for a subtraction.
    typedef struct packed {
        fp_op_e   op;
        logic     bypass;
        fp_word_t bypass_word;
        logic     sign_a;
        logic     sign_b;
        fp_exp_t  exp;
        fp_sig_t  sig_a;
        fp_sig_t  sig_b;
        logic     sticky;
    } fp_aligned_t;

    // unnormalized result of the arithmetic stage.
    typedef struct packed {
        logic     bypass;
        fp_word_t bypass_word;
        logic     sign;
        fp_exp_t  exp;
        fp_mag_t  mag;
        logic     sticky;
    } fp_raw_t;

endpackage

`default_nettype wire

//--- fp_align_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module fp_align_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  fp_alu_pkg::fp_word_t     a,
    input  fp_alu_pkg::fp_word_t     b,
    input  logic [`FP_OP_WIDTH-1:0]  op,
    output logic                     aligned_valid,
    output fp_alu_pkg::fp_aligned_t  aligned
);

    fp_alu_pkg::fp_op_e         op_e;
    logic                       sign_a;
    logic                       sign_b;
    fp_alu_pkg::fp_exp_t        exp_a;
    fp_alu_pkg::fp_exp_t        exp_b;
    fp_alu_pkg::fp_sig_t        sig_a;
    fp_alu_pkg::fp_sig_t        sig_b;
    logic                       a_is_zero;
    logic                       b_is_zero;
    logic                       slt_true;
    logic                       a_exp_ge;
    fp_alu_pkg::fp_exp_t        exp_diff;
    fp_alu_pkg::fp_sig_t        sig_small;
    logic [2*`FP_SIG_WIDTH-1:0] shift_ext;
    fp_alu_pkg::fp_sig_t        sig_shifted;
    logic                       shift_sticky;
    fp_alu_pkg::fp_aligned_t    aligned_d;

    // unknown codes are treated as NOP.
    always_comb begin
        case (op)
            `FP_OP_ADD: op_e = fp_alu_pkg::op_add;
            `FP_OP_SUB: op_e = fp_alu_pkg::op_sub;
            `FP_OP_MUL: op_e = fp_alu_pkg::op_mul;
            `FP_OP_SLT: op_e = fp_alu_pkg::op_slt;
            default:    op_e = fp_alu_pkg::op_nop;
        endcase
    end

    assign sign_a    = a[`FP_SIGN_BIT];
    assign sign_b    = b[`FP_SIGN_BIT];
    assign exp_a     = a[`FP_EXP_LSB +: `FP_EXP_WIDTH];
    assign exp_b     = b[`FP_EXP_LSB +: `FP_EXP_WIDTH];
    assign sig_a     = {1'b1, a[`FP_FRAC_WIDTH-1:0]};
    assign sig_b     = {1'b1, b[`FP_FRAC_WIDTH-1:0]};
    assign a_is_zero = (a == '0);
    assign b_is_zero = (b == '0);

    // with equal signs the exponent sits above the fraction, so the low 31 bits
    // compare as one unsigned number.
    always_comb begin
        if (sign_a != sign_b) begin
            slt_true = sign_a;
        end else if (!sign_a) begin
            slt_true = (a[`FP_SIGN_BIT-1:0] < b[`FP_SIGN_BIT-1:0]);
        end else begin
            slt_true = (a[`FP_SIGN_BIT-1:0] > b[`FP_SIGN_BIT-1:0]);
        end
    end

    assign a_exp_ge  = (exp_a >= exp_b);
    assign exp_diff  = a_exp_ge ? exp_a - exp_b : exp_b - exp_a;
    assign sig_small = a_exp_ge ? sig_b : sig_a;

    // bits shifted past the significand land in the low half and form the sticky bit.
    always_comb begin
        shift_ext = {sig_small, {`FP_SIG_WIDTH{1'b0}}} >> exp_diff;
        if (exp_diff > `FP_SIG_WIDTH) begin
            sig_shifted  = '0;
            shift_sticky = |sig_small;
        end else begin
            sig_shifted  = shift_ext[2*`FP_SIG_WIDTH-1 -: `FP_SIG_WIDTH];
            shift_sticky = |shift_ext[`FP_SIG_WIDTH-1:0];
        end
    end

    always_comb begin
        aligned_d        = '0;
        aligned_d.op     = op_e;
        aligned_d.sign_a = sign_a;
        aligned_d.sign_b = sign_b ^ (op_e == fp_alu_pkg::op_sub);
        aligned_d.sig_a  = sig_a;
        aligned_d.sig_b  = sig_b;
        case (op_e)
            fp_alu_pkg::op_add, fp_alu_pkg::op_sub: begin
                if (b_is_zero) begin
                    aligned_d.bypass      = 1'b1;
                    aligned_d.bypass_word = a;
                end else if (a_is_zero) begin
                    aligned_d.bypass      = 1'b1;
                    aligned_d.bypass_word = {aligned_d.sign_b, b[`FP_SIGN_BIT-1:0]};
                end else begin
                    aligned_d.exp    = a_exp_ge ? exp_a : exp_b;
                    aligned_d.sig_a  = a_exp_ge ? sig_a : sig_shifted;
                    aligned_d.sig_b  = a_exp_ge ? sig_shifted : sig_b;
                    aligned_d.sticky = shift_sticky;
                end
            end
            fp_alu_pkg::op_mul: begin
                if (a_is_zero || b_is_zero) begin
                    aligned_d.bypass      = 1'b1;
                    aligned_d.bypass_word = '0;
                end else begin
                    aligned_d.exp = exp_a + exp_b - `FP_BIAS_MUL;
                end
            end
            fp_alu_pkg::op_slt: begin
                aligned_d.bypass      = 1'b1;
                aligned_d.bypass_word = {{(`FP_WIDTH-1){1'b0}}, slt_true};
            end
            default: begin
                aligned_d.bypass      = 1'b1;
                aligned_d.bypass_word = a;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aligned_valid <= 1'b0;
        end else begin
            aligned_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            aligned <= aligned_d;
        end
    end

    // every accepted input leaves this stage one cycle later.
    align_valid_delay: assert property (
        @(posedge clk) disable iff (!rst_n) aligned_valid == $past(in_valid)
    );

endmodule

`default_nettype wire

//--- fp_arith_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module fp_arith_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    aligned_valid,
    input  fp_alu_pkg::fp_aligned_t aligned,
    output logic                    raw_valid,
    output fp_alu_pkg::fp_raw_t     raw
);

    fp_alu_pkg::fp_prod_t prod;
    fp_alu_pkg::fp_raw_t  raw_d;

    assign prod = aligned.sig_a * aligned.sig_b;

    always_comb begin
        raw_d             = '0;
        raw_d.bypass      = aligned.bypass;
        raw_d.bypass_word = aligned.bypass_word;
        raw_d.exp         = aligned.exp;
        raw_d.sticky      = aligned.sticky;
        if (!aligned.bypass) begin
            if (aligned.op == fp_alu_pkg::op_mul) begin
                raw_d.sign = aligned.sign_a ^ aligned.sign_b;
                // the product of two normalized significands has its leading one
                // in bit 47 or bit 46.
                if (prod[2*`FP_SIG_WIDTH-1]) begin
                    raw_d.mag    = {1'b0, prod[2*`FP_SIG_WIDTH-1 -: `FP_SIG_WIDTH]};
                    raw_d.sticky = aligned.sticky | (|prod[`FP_SIG_WIDTH-1:0]);
                end else begin
                    raw_d.mag    = {1'b0, prod[2*`FP_SIG_WIDTH-2 -: `FP_SIG_WIDTH]};
                    raw_d.sticky = aligned.sticky | (|prod[`FP_SIG_WIDTH-2:0]);
                    raw_d.exp    = aligned.exp - 1'b1;
                end
            end else if (aligned.sign_a == aligned.sign_b) begin
                raw_d.sign = aligned.sign_a;
                raw_d.mag  = {1'b0, aligned.sig_a} + {1'b0, aligned.sig_b};
            end else if (aligned.sig_a > aligned.sig_b) begin
                raw_d.sign = aligned.sign_a;
                raw_d.mag  = {1'b0, aligned.sig_a - aligned.sig_b};
            end else if (aligned.sig_b > aligned.sig_a) begin
                raw_d.sign = aligned.sign_b;
                raw_d.mag  = {1'b0, aligned.sig_b - aligned.sig_a};
            end else begin
                // exact cancellation gives a clean zero word.
                raw_d.bypass      = 1'b1;
                raw_d.bypass_word = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raw_valid <= 1'b0;
        end else begin
            raw_valid <= aligned_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (aligned_valid) begin
            raw <= raw_d;
        end
    end

    arith_valid_delay: assert property (
        @(posedge clk) disable iff (!rst_n) raw_valid == $past(aligned_valid)
    );

endmodule

`default_nettype wire

//--- fp_normalize_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module fp_normalize_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 raw_valid,
    input  fp_alu_pkg::fp_raw_t  raw,
    output logic                 out_valid,
    output fp_alu_pkg::fp_word_t result,
    output logic                 inexact
);

    localparam int lz_width = $clog2(`FP_SIG_WIDTH + 1);

    logic [lz_width-1:0]  lz;
    fp_alu_pkg::fp_mag_t  mag_n;
    fp_alu_pkg::fp_exp_t  exp_n;
    logic                 sticky_n;
    fp_alu_pkg::fp_word_t word_d;
    logic                 inexact_d;

    // zeros above the leading one, scanned from the top bit down.
    function automatic logic [lz_width-1:0] lead_zeros(input fp_alu_pkg::fp_sig_t v);
        logic [lz_width-1:0] n;
        logic                found;
        n     = '0;
        found = 1'b0;
        for (int i = `FP_SIG_WIDTH - 1; i >= 0; i--) begin
            if (!found) begin
                if (v[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 1'b1;
                end
            end
        end
        return n;
    endfunction

    assign lz = lead_zeros(raw.mag[`FP_SIG_WIDTH-1:0]);

    always_comb begin
        if (raw.mag[`FP_SIG_WIDTH]) begin
            // carry out of the addition.
            mag_n    = raw.mag >> 1;
            sticky_n = raw.sticky | raw.mag[0];
            exp_n    = raw.exp + 1'b1;
        end else begin
            mag_n    = raw.mag << lz;
            sticky_n = raw.sticky;
            exp_n    = raw.exp - fp_alu_pkg::fp_exp_t'(lz);
        end
    end

    always_comb begin
        if (raw.bypass) begin
            word_d    = raw.bypass_word;
            inexact_d = 1'b0;
        end else begin
            word_d    = {raw.sign, exp_n, mag_n[`FP_FRAC_WIDTH-1:0]};
            inexact_d = sticky_n;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            inexact   <= 1'b0;
        end else begin
            out_valid <= raw_valid;
            if (raw_valid) begin
                result  <= word_d;
                inexact <= inexact_d;
            end
        end
    end

    norm_valid_delay: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid == $past(raw_valid)
    );

endmodule

`default_nettype wire

//--- fp_alu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module fp_alu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  fp_alu_pkg::fp_word_t    a,
    input  fp_alu_pkg::fp_word_t    b,
    input  logic [`FP_OP_WIDTH-1:0] op,
    output logic                    out_valid,
    output fp_alu_pkg::fp_word_t    result,
    output logic                    inexact
);

    logic                    aligned_valid;
    fp_alu_pkg::fp_aligned_t aligned;
    logic                    raw_valid;
    fp_alu_pkg::fp_raw_t     raw;

    fp_align_stage u_align (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .a             (a),
        .b             (b),
        .op            (op),
        .aligned_valid (aligned_valid),
        .aligned       (aligned)
    );

    fp_arith_stage u_arith (
        .clk           (clk),
        .rst_n         (rst_n),
        .aligned_valid (aligned_valid),
        .aligned       (aligned),
        .raw_valid     (raw_valid),
        .raw           (raw)
    );

    fp_normalize_stage u_norm (
        .clk       (clk),
        .rst_n     (rst_n),
        .raw_valid (raw_valid),
        .raw       (raw),
        .out_valid (out_valid),
        .result    (result),
        .inexact   (inexact)
    );

    // the whole pipeline has a fixed latency with no stalls.
    top_latency: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, `FP_LATENCY)
    );

endmodule

`default_nettype wire

//--- tb_fp_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module tb_fp_alu;

    localparam int num_directed = 27;
    localparam int num_random   = 40;
    localparam int num_stream   = 200;
    localparam int num_gapped   = 20;
    localparam int max_cycles   =
        2 * (num_directed + num_random + num_stream + num_gapped) + 50;

    typedef struct packed {
        logic [31:0] word;
        logic        inexact;
        logic [31:0] due;
    } expect_t;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          in_valid;
    fp_alu_pkg::fp_word_t          a;
    fp_alu_pkg::fp_word_t          b;
    logic [`FP_OP_WIDTH-1:0]       op;
    logic                          out_valid;
    fp_alu_pkg::fp_word_t          result;
    logic                          inexact;

    integer  seed = 32'ha29;
    int      cycle = 0;
    int      errors = 0;
    int      issued = 0;
    expect_t expected_q[$];
    logic [4:0] codes [0:5] = '{`FP_OP_ADD, `FP_OP_SUB, `FP_OP_MUL, `FP_OP_SLT,
                                `FP_OP_NOP, 5'd3};

    fp_alu_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .op        (op),
        .out_valid (out_valid),
        .result    (result),
        .inexact   (inexact)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // expected result word in bits 31..0 and the inexact flag in bit 32.
    function automatic logic [32:0] ref_fp_alu(input logic [31:0] fa, input logic [31:0] fb,
                                               input logic [4:0] code);
        logic        sa;
        logic        sb;
        logic        sign;
        logic [7:0]  ea;
        logic [7:0]  eb;
        logic [7:0]  e;
        int          diff;
        logic [47:0] ma;
        logic [47:0] mb;
        logic [47:0] sig_low;
        logic [47:0] mag;
        logic [47:0] prod;
        logic        sticky;
        logic [32:0] res;
        sa     = fa[31];
        sb     = fb[31];
        ea     = fa[30:23];
        eb     = fb[30:23];
        ma     = {24'd0, 1'b1, fa[22:0]};
        mb     = {24'd0, 1'b1, fb[22:0]};
        sticky = 1'b0;
        res    = {1'b0, fa};
        if (code == `FP_OP_ADD || code == `FP_OP_SUB) begin
            if (code == `FP_OP_SUB) begin
                sb = ~sb;
            end
            if (fb == 32'd0) begin
                res = {1'b0, fa};
            end else if (fa == 32'd0) begin
                res = {1'b0, sb, fb[30:0]};
            end else begin
                e       = (ea >= eb) ? ea : eb;
                diff    = (ea >= eb) ? int'(ea - eb) : int'(eb - ea);
                sig_low = (ea >= eb) ? mb : ma;
                if (diff >= 25) begin
                    sticky  = 1'b1;
                    sig_low = 48'd0;
                end else begin
                    sticky  = ((sig_low & ((48'd1 << diff) - 48'd1)) != 48'd0);
                    sig_low = sig_low >> diff;
                end
                if (ea >= eb) begin
                    mb = sig_low;
                end else begin
                    ma = sig_low;
                end
                if (sa == sb) begin
                    mag  = ma + mb;
                    sign = sa;
                end else begin
                    mag  = (ma > mb) ? ma - mb : mb - ma;
                    sign = (ma > mb) ? sa : sb;
                end
                if (mag == 48'd0) begin
                    res = 33'd0;
                end else begin
                    if (mag[24]) begin
                        sticky = sticky | mag[0];
                        mag    = mag >> 1;
                        e      = e + 8'd1;
                    end
                    while (!mag[23]) begin
                        mag = mag << 1;
                        e   = e - 8'd1;
                    end
                    res = {sticky, sign, e, mag[22:0]};
                end
            end
        end else if (code == `FP_OP_MUL) begin
            if (fa == 32'd0 || fb == 32'd0) begin
                res = 33'd0;
            end else begin
                prod = ma * mb;
                e    = ea + eb - 8'd126;
                if (prod[47]) begin
                    mag    = {24'd0, prod[47:24]};
                    sticky = |prod[23:0];
                end else begin
                    mag    = {24'd0, prod[46:23]};
                    sticky = |prod[22:0];
                    e      = e - 8'd1;
                end
                res = {sticky, sa ^ sb, e, mag[22:0]};
            end
        end else if (code == `FP_OP_SLT) begin
            if (sa != sb) begin
                res = {32'd0, sa};
            end else if (!sa) begin
                res = {32'd0, (ea < eb) || (ea == eb && fa[22:0] < fb[22:0])};
            end else begin
                res = {32'd0, (ea > eb) || (ea == eb && fa[22:0] > fb[22:0])};
            end
        end
        return res;
    endfunction

    // exponents stay inside 64..190 and about one word in sixteen is zero.
    function automatic logic [31:0] random_operand();
        logic [7:0] ex;
        if (($random(seed) & 15) == 0) begin
            return 32'd0;
        end
        ex = 8'(64 + ($unsigned($random(seed)) % 127));
        return {1'($random(seed)), ex, 23'($random(seed))};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic issue_op(input logic [31:0] op_a, input logic [31:0] op_b,
                            input logic [4:0] code);
        expect_t     e;
        logic [32:0] r;
        @(posedge clk);
        #1;
        in_valid  = 1'b1;
        a         = op_a;
        b         = op_b;
        op        = code;
        r         = ref_fp_alu(op_a, op_b, code);
        e.word    = r[31:0];
        e.inexact = r[32];
        e.due     = cycle + `FP_LATENCY;
        expected_q.push_back(e);
        issued++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        expect_t e;
        if (rst_n && out_valid) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("Error at %0t: out_valid is high with no operation pending", $time);
            end else begin
                e = expected_q.pop_front();
                check_value("result", e.word, result);
                check_value("inexact", {31'd0, e.inexact}, {31'd0, inexact});
                check_value("out_valid cycle", e.due, cycle);
            end
        end
    end

    always @(posedge clk) begin
        if (cycle >= max_cycles) begin
            $display("Error: the run did not finish within %0d cycles", max_cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        op       = '0;
        rst_n    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle_cycles(5);
        check_value("result", 32'd0, result);
        check_value("inexact", 32'd0, {31'd0, inexact});

        // add and subtract corner cases.
        issue_op(32'h3f800000, 32'h3f800000, `FP_OP_SUB);
        issue_op(32'h3fc00000, 32'h3fc00000, `FP_OP_ADD);
        issue_op(32'h3f800001, 32'h3f800000, `FP_OP_SUB);
        issue_op(32'h3f800000, 32'hbf7fffff, `FP_OP_ADD);
        issue_op(32'h3f800000, 32'h33800000, `FP_OP_ADD);
        issue_op(32'h3f800000, 32'h2f800000, `FP_OP_ADD);
        issue_op(32'h40490fdb, 32'h00000000, `FP_OP_ADD);
        issue_op(32'h00000000, 32'hc0490fdb, `FP_OP_ADD);
        issue_op(32'h00000000, 32'h40490fdb, `FP_OP_SUB);
        issue_op(32'h40490fdb, 32'h00000000, `FP_OP_SUB);
        idle_cycles(2);

        issue_op(32'h3fc00000, 32'h3fc00000, `FP_OP_MUL);
        issue_op(32'h3f800000, 32'h40000000, `FP_OP_MUL);
        issue_op(32'h00000000, 32'h40490fdb, `FP_OP_MUL);
        issue_op(32'hc0490fdb, 32'h00000000, `FP_OP_MUL);
        issue_op(32'hc0000000, 32'h3fa00000, `FP_OP_MUL);
        idle_cycles(2);

        issue_op(32'h3f800000, 32'h40000000, `FP_OP_SLT);
        issue_op(32'h40000000, 32'h3f800000, `FP_OP_SLT);
        issue_op(32'hbf800000, 32'h3f800000, `FP_OP_SLT);
        issue_op(32'h3f800000, 32'hbf800000, `FP_OP_SLT);
        issue_op(32'hbf800000, 32'hc0000000, `FP_OP_SLT);
        issue_op(32'hc0000000, 32'hbf800000, `FP_OP_SLT);
        issue_op(32'h3f800001, 32'h3f800002, `FP_OP_SLT);
        issue_op(32'hbf800001, 32'hbf800002, `FP_OP_SLT);
        issue_op(32'h3f800000, 32'h3f800000, `FP_OP_SLT);
        issue_op(32'h12345678, 32'h9abcdef0, `FP_OP_NOP);
        issue_op(32'h12345678, 32'h9abcdef0, 5'd3);
        issue_op(32'hdeadbeef, 32'h01234567, 5'd31);
        idle_cycles(2);

        for (int i = 0; i < num_random; i++) begin
            issue_op(random_operand(), random_operand(), codes[i % 3]);
        end
        idle_cycles(3);

        for (int i = 0; i < num_stream; i++) begin
            issue_op(random_operand(), random_operand(), codes[$unsigned($random(seed)) % 6]);
        end
        idle_cycles(1);

        for (int i = 0; i < num_gapped; i++) begin
            issue_op(random_operand(), random_operand(), codes[$unsigned($random(seed)) % 6]);
            idle_cycles(1 + $unsigned($random(seed)) % 3);
        end
        idle_cycles(`FP_LATENCY + 3);

        if (expected_q.size() != 0) begin
            errors++;
            $display("Error: %0d operations produced no output", expected_q.size());
        end
        $display("issued %0d operations, errors %0d", issued, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
fp_alu_pkg.sv
fp_align_stage.sv
fp_arith_stage.sv
fp_normalize_stage.sv
fp_alu_top.sv
tb_fp_alu.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then search the log for the fail message.
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_fp_alu \
    > build.log 2>&1 &&
./obj_dir/Vtb_fp_alu > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
exit 0
